//--- verilog.f
hw/lsb_pkg.sv
hw/ls_buffer.sv
hw/data_mem.sv
hw/cdb_arbiter.sv
hw/lsu_top.sv
verif/lsu_props.sv
verif/lsu_tb.sv

//--- verif/lsu_tb.sv
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TAGS  = 16;
    localparam int MEM_BYTES = 1024;
    localparam int K_DISP    = 0;
    localparam int K_COMMIT  = 1;
    localparam int K_EX      = 2;
    localparam int K_FULL    = 3;

    // extra holds the latency flag for dispatch, the held tag for ex and the level for full
    typedef struct {
        int               kind;
        lsb_pkg::mem_op_t op;
        lsb_pkg::tag_t    tag;
        lsb_pkg::tag_t    b_tag;
        lsb_pkg::data_t   b;
        lsb_pkg::tag_t    d_tag;
        lsb_pkg::data_t   d;
        lsb_pkg::imm_t    imm;
        int               gap;
        bit               sync;
        int               extra;
        int               test;
    } row_t;

    logic             clk;
    logic             rst;
    logic             dp_en;
    lsb_pkg::mem_op_t dp_op;
    lsb_pkg::tag_t    dp_tag;
    lsb_pkg::imm_t    dp_imm;
    lsb_pkg::tag_t    dp_rs1_tag;
    lsb_pkg::data_t   dp_rs1_data;
    lsb_pkg::tag_t    dp_rs2_tag;
    lsb_pkg::data_t   dp_rs2_data;
    logic             commit_en;
    lsb_pkg::tag_t    commit_tag;
    logic             ex_en;
    lsb_pkg::tag_t    ex_tag;
    lsb_pkg::data_t   ex_data;
    logic             ex_stall;
    logic             cdb_en;
    lsb_pkg::tag_t    cdb_tag;
    lsb_pkg::data_t   cdb_data;
    logic             full;

    row_t             rows[$];
    lsb_pkg::tag_t    mon_tag[$];
    lsb_pkg::data_t   mon_data[$];
    int               mon_cyc[$];
    lsb_pkg::tag_t    exq_tag[$];
    lsb_pkg::data_t   exq_data[$];
    lsb_pkg::tag_t    pq[$];
    logic [7:0]       ref_mem[int];

    // per-tag view of what was dispatched
    lsb_pkg::mem_op_t p_op[NUM_TAGS];
    lsb_pkg::imm_t    p_imm[NUM_TAGS];
    lsb_pkg::tag_t    p_b_tag[NUM_TAGS];
    lsb_pkg::data_t   p_b[NUM_TAGS];
    lsb_pkg::tag_t    p_d_tag[NUM_TAGS];
    lsb_pkg::data_t   p_d[NUM_TAGS];
    bit               p_lat[NUM_TAGS];
    int               p_cyc[NUM_TAGS];

    int               cyc = 0;
    int               limit = 100000;
    int               checks = 0;
    int               errs = 0;
    int               seed;
    lsb_pkg::data_t   rnd[4];
    string            names[7];

    lsu_top #(.NUM_TAGS(NUM_TAGS), .MEM_BYTES(MEM_BYTES)) DUT (
        .clk(clk), .rst(rst),
        .dp_en(dp_en), .dp_op(dp_op), .dp_tag(dp_tag), .dp_imm(dp_imm),
        .dp_rs1_tag(dp_rs1_tag), .dp_rs1_data(dp_rs1_data),
        .dp_rs2_tag(dp_rs2_tag), .dp_rs2_data(dp_rs2_data),
        .commit_en(commit_en), .commit_tag(commit_tag),
        .ex_en(ex_en), .ex_tag(ex_tag), .ex_data(ex_data), .ex_stall(ex_stall),
        .cdb_en(cdb_en), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .full(full)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            $display("run hung waiting for a CDB result after %0d cycles", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && cdb_en) begin
            mon_tag.push_back(cdb_tag);
            mon_data.push_back(cdb_data);
            mon_cyc.push_back(cyc);
        end
    end

    task automatic check_data(lsb_pkg::data_t got, lsb_pkg::data_t exp, string msg);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got %h, expected %h", $time, msg, got, exp);
            errs++;
        end
    endtask

    task automatic check_tag(lsb_pkg::tag_t got, lsb_pkg::tag_t exp, string msg);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got tag %0d, expected %0d", $time, msg, got, exp);
            errs++;
        end
    endtask

    task automatic check_flag(logic got, logic exp, string msg);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got %b, expected %b", $time, msg, got, exp);
            errs++;
        end
    endtask

    task automatic check_count(int got, int exp, string msg);
        checks++;
        if (got != exp) begin
            $display("ERROR at %0t: %s: got %0d, expected %0d", $time, msg, got, exp);
            errs++;
        end
    endtask

    function automatic bit is_ld(lsb_pkg::mem_op_t op);
        return op inside {lsb_pkg::LB, lsb_pkg::LH, lsb_pkg::LW, lsb_pkg::LBU, lsb_pkg::LHU};
    endfunction

    function automatic lsb_pkg::addr_t eff_addr(int t);
        return p_b[t] + {{20{p_imm[t][11]}}, p_imm[t]};
    endfunction

    function automatic logic [7:0] rbyte(lsb_pkg::addr_t a);
        int k;
        k = int'(a) & (MEM_BYTES - 1);
        return ref_mem.exists(k) ? ref_mem[k] : 8'h00;
    endfunction

    function automatic lsb_pkg::data_t ref_load(lsb_pkg::mem_op_t op, lsb_pkg::addr_t a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = rbyte(a);
        b1 = rbyte(a + 1);
        case (op)
            lsb_pkg::LB:  return {{24{b0[7]}}, b0};
            lsb_pkg::LBU: return {24'h0, b0};
            lsb_pkg::LH:  return {{16{b1[7]}}, b1, b0};
            lsb_pkg::LHU: return {16'h0, b1, b0};
            default:      return {rbyte(a + 3), rbyte(a + 2), b1, b0};
        endcase
    endfunction

    task automatic ref_store(lsb_pkg::mem_op_t op, lsb_pkg::addr_t a, lsb_pkg::data_t d);
        int n;
        n = (op == lsb_pkg::SB) ? 1 : (op == lsb_pkg::SH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[int'(a + i) & (MEM_BYTES - 1)] = d[8*i +: 8];
        end
    endtask

    task automatic add_row(int kind, lsb_pkg::mem_op_t op, int tag, int b_tag,
                           lsb_pkg::data_t b, int d_tag, lsb_pkg::data_t d,
                           int imm, int gap, bit sync, int extra, int test);
        row_t r;
        r.kind  = kind;
        r.op    = op;
        r.tag   = lsb_pkg::tag_t'(tag);
        r.b_tag = lsb_pkg::tag_t'(b_tag);
        r.b     = b;
        r.d_tag = lsb_pkg::tag_t'(d_tag);
        r.d     = d;
        r.imm   = lsb_pkg::imm_t'(imm);
        r.gap   = gap;
        r.sync  = sync;
        r.extra = extra;
        r.test  = test;
        rows.push_back(r);
    endtask

    task automatic apply_dispatch(row_t r);
        @(negedge clk);
        dp_en       = 1'b1;
        dp_op       = r.op;
        dp_tag      = r.tag;
        dp_imm      = r.imm;
        dp_rs1_tag  = r.b_tag;
        dp_rs1_data = r.b;
        dp_rs2_tag  = r.d_tag;
        dp_rs2_data = r.d;
        p_op[r.tag]    = r.op;
        p_imm[r.tag]   = r.imm;
        p_b_tag[r.tag] = r.b_tag;
        p_b[r.tag]     = r.b;
        p_d_tag[r.tag] = r.d_tag;
        p_d[r.tag]     = r.d;
        p_lat[r.tag]   = (r.extra != 0);
        // strobe is taken at the coming edge
        p_cyc[r.tag]   = cyc + 1;
        if (is_ld(r.op)) begin
            pq.push_back(r.tag);
        end
        @(negedge clk);
        dp_en = 1'b0;
        dp_op = lsb_pkg::NONE;
    endtask

    task automatic apply_commit(row_t r);
        @(negedge clk);
        commit_en  = 1'b1;
        commit_tag = r.tag;
        ref_store(p_op[r.tag], eff_addr(r.tag), p_d[r.tag]);
        @(negedge clk);
        commit_en = 1'b0;
    endtask

    task automatic apply_ex(row_t r);
        logic stalled;
        @(negedge clk);
        ex_en   = 1'b1;
        ex_tag  = r.tag;
        ex_data = r.d;
        exq_tag.push_back(r.tag);
        exq_data.push_back(r.d);
        for (int t = 1; t < NUM_TAGS; t++) begin
            if (p_b_tag[t] == r.tag) begin
                p_b[t]     = r.d;
                p_b_tag[t] = '0;
            end
            if (p_d_tag[t] == r.tag) begin
                p_d[t]     = r.d;
                p_d_tag[t] = '0;
            end
        end
        #1;
        stalled = ex_stall;
        check_flag(stalled, r.extra != 0, "ex_stall");
        @(negedge clk);
        if (stalled) begin
            check_tag(cdb_tag, lsb_pkg::tag_t'(r.extra), "load ahead of held ex result");
            @(negedge clk);
        end
        ex_en = 1'b0;
    endtask

    task automatic wait_result(lsb_pkg::tag_t tag, lsb_pkg::data_t exp, bit lat, int start);
        int idx;
        idx = -1;
        while (idx < 0) begin
            foreach (mon_tag[k]) begin
                if (idx < 0 && mon_tag[k] == tag) begin
                    idx = k;
                end
            end
            if (idx < 0) begin
                @(negedge clk);
            end
        end
        check_data(mon_data[idx], exp, $sformatf("CDB data of tag %0d", tag));
        if (lat) begin
            check_count(mon_cyc[idx] - start, 4, "dispatch to CDB latency");
        end
        mon_tag.delete(idx);
        mon_data.delete(idx);
        mon_cyc.delete(idx);
    endtask

    task automatic drain_results();
        lsb_pkg::tag_t keep[$];
        while (exq_tag.size() > 0) begin
            wait_result(exq_tag[0], exq_data[0], 1'b0, 0);
            void'(exq_tag.pop_front());
            void'(exq_data.pop_front());
        end
        foreach (pq[k]) begin
            if (p_b_tag[pq[k]] == '0) begin
                wait_result(pq[k], ref_load(p_op[pq[k]], eff_addr(pq[k])),
                            p_lat[pq[k]], p_cyc[pq[k]]);
            end else begin
                keep.push_back(pq[k]);
            end
        end
        pq = keep;
        // monitor has finished the previous falling edge by now
        @(posedge clk);
        if (mon_tag.size() != 0) begin
            $display("unexpected CDB broadcast of tag %0d seen before %0t", mon_tag[0], $time);
            errs++;
            mon_tag.delete();
            mon_data.delete();
            mon_cyc.delete();
        end
    endtask

    initial begin
        int test_errs;
        clk = 1'b0;
        rst = 1'b1;
        dp_en = 1'b0;
        dp_op = lsb_pkg::NONE;
        dp_tag = '0;
        dp_imm = '0;
        dp_rs1_tag = '0;
        dp_rs1_data = '0;
        dp_rs2_tag = '0;
        dp_rs2_data = '0;
        commit_en = 1'b0;
        commit_tag = '0;
        ex_en = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        test_errs = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            p_b_tag[t] = '0;
            p_d_tag[t] = '0;
        end
        seed = 32'h61d282d2;
        foreach (rnd[k]) begin
            rnd[k] = $random(seed);
        end
        names = '{"", "store then load", "operand wakeup", "store data wakeup",
                  "arbitration", "capacity", "latency"};

        add_row(K_DISP, lsb_pkg::SW, 1, 0, 32'h100, 0, rnd[0], 0, 0, 0, 0, 1);
        add_row(K_COMMIT, lsb_pkg::NONE, 1, 0, 0, 0, 0, 0, 2, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::SH, 2, 0, 32'h100, 0, rnd[1], 4, 0, 0, 0, 1);
        add_row(K_COMMIT, lsb_pkg::NONE, 2, 0, 0, 0, 0, 0, 2, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::SB, 3, 0, 32'h100, 0, rnd[2], 7, 0, 0, 0, 1);
        add_row(K_COMMIT, lsb_pkg::NONE, 3, 0, 0, 0, 0, 0, 3, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::LW, 4, 0, 32'h108, 0, 0, -8, 0, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::LH, 5, 0, 32'h100, 0, 0, 4, 0, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::LHU, 6, 0, 32'h100, 0, 0, 4, 0, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::LB, 7, 0, 32'h100, 0, 0, 7, 0, 0, 0, 1);
        add_row(K_DISP, lsb_pkg::LBU, 8, 0, 32'h100, 0, 0, 7, 0, 1, 0, 1);
        add_row(K_DISP, lsb_pkg::LW, 1, 9, 0, 0, 0, 4, 3, 1, 0, 2);
        add_row(K_EX, lsb_pkg::NONE, 9, 0, 0, 0, 32'h100, 0, 0, 1, 0, 2);
        add_row(K_DISP, lsb_pkg::SW, 2, 0, 32'h200, 10, 0, 0, 0, 0, 0, 3);
        add_row(K_EX, lsb_pkg::NONE, 10, 0, 0, 0, rnd[3], 0, 0, 1, 0, 3);
        add_row(K_COMMIT, lsb_pkg::NONE, 2, 0, 0, 0, 0, 0, 3, 0, 0, 3);
        add_row(K_DISP, lsb_pkg::LW, 3, 0, 32'h200, 0, 0, 0, 0, 1, 0, 3);
        add_row(K_DISP, lsb_pkg::LW, 4, 0, 32'h100, 0, 0, 0, 2, 0, 0, 4);
        add_row(K_EX, lsb_pkg::NONE, 11, 0, 0, 0, 32'h5a5a, 0, 0, 1, 4, 4);
        for (int i = 1; i < NUM_TAGS; i++) begin
            add_row(K_DISP, lsb_pkg::LW, i, 12, 0, 0, 0, 4 * i, 0, 0, 0, 5);
        end
        add_row(K_FULL, lsb_pkg::NONE, 0, 0, 0, 0, 0, 0, 0, 0, 1, 5);
        add_row(K_EX, lsb_pkg::NONE, 12, 0, 0, 0, 32'h100, 0, 0, 1, 0, 5);
        add_row(K_FULL, lsb_pkg::NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0, 5);
        add_row(K_DISP, lsb_pkg::LW, 1, 0, 32'h100, 0, 0, 0, 0, 1, 1, 6);
        limit = 20 * rows.size() + 50;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (rows[i]) begin
            case (rows[i].kind)
                K_DISP:   apply_dispatch(rows[i]);
                K_COMMIT: apply_commit(rows[i]);
                K_EX:     apply_ex(rows[i]);
                default: begin
                    @(negedge clk);
                    check_flag(full, rows[i].extra != 0, "full");
                end
            endcase
            repeat (rows[i].gap) @(negedge clk);
            if (rows[i].sync) begin
                drain_results();
            end
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                $display("test %0d %s: %0d errors", rows[i].test, names[rows[i].test],
                         errs - test_errs);
                test_errs = errs;
            end
        end

        $display("checks %0d, errors %0d", checks, errs);
        if (errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/lsu_props.sv
`default_nettype none

module lsu_props #(
    parameter int NUM_TAGS = 16
) (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                rsp_en,
    input wire logic                ex_en,
    input wire logic                ex_stall,
    input wire logic                cdb_en,
    input wire logic                mem_en,
    input wire logic                mem_we,
    input wire lsb_pkg::tag_t       mem_tag,
    input wire logic [NUM_TAGS-1:0] occupied
);
    timeunit 1ns;
    timeprecision 1ps;

    // occupancy seen when the request was formed
    logic [NUM_TAGS-1:0] occ_q;

    always_ff @(posedge clk) begin
        occ_q <= occupied;
    end

    // a load read reaches the CDB three cycles after its memory request
    cdb_has_source: assert property (@(posedge clk) disable iff (rst)
        cdb_en |-> $past(ex_en) || $past(mem_en && !mem_we, 3))
        else $error("CDB broadcast without an execute or load request behind it");

    mem_from_live_entry: assert property (@(posedge clk) disable iff (rst)
        mem_en |-> occ_q[mem_tag])
        else $error("memory request for an empty entry");

    stall_needs_rsp: assert property (@(posedge clk) disable iff (rst)
        !$past(mem_en && !mem_we, 2) |-> !rsp_en && !ex_stall)
        else $error("load response or ex_stall without a load read two cycles earlier");

endmodule

bind lsu_top lsu_props #(.NUM_TAGS(NUM_TAGS)) u_lsu_props (
    .clk      (clk),
    .rst      (rst),
    .rsp_en   (u_cdb_arbiter.rsp_en),
    .ex_en    (u_cdb_arbiter.ex_en),
    .ex_stall (u_cdb_arbiter.ex_stall),
    .cdb_en   (u_cdb_arbiter.cdb_en),
    .mem_en   (u_ls_buffer.mem_en),
    .mem_we   (u_ls_buffer.mem_we),
    .mem_tag  (u_ls_buffer.mem_tag),
    .occupied (u_ls_buffer.occupied)
);

`default_nettype wire

//--- hw/lsu_top.sv
`default_nettype none

module lsu_top #(
    parameter int NUM_TAGS  = 16,
    parameter int MEM_BYTES = 1024
) (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             dp_en,
    input  wire lsb_pkg::mem_op_t dp_op,
    input  wire lsb_pkg::tag_t    dp_tag,
    input  wire lsb_pkg::imm_t    dp_imm,
    input  wire lsb_pkg::tag_t    dp_rs1_tag,
    input  wire lsb_pkg::data_t   dp_rs1_data,
    input  wire lsb_pkg::tag_t    dp_rs2_tag,
    input  wire lsb_pkg::data_t   dp_rs2_data,

    input  wire logic             commit_en,
    input  wire lsb_pkg::tag_t    commit_tag,

    input  wire logic             ex_en,
    input  wire lsb_pkg::tag_t    ex_tag,
    input  wire lsb_pkg::data_t   ex_data,
    output logic                  ex_stall,

    output logic                  cdb_en,
    output lsb_pkg::tag_t         cdb_tag,
    output lsb_pkg::data_t        cdb_data,
    output logic                  full
);

    // buffer to memory
    logic             mem_en;
    logic             mem_we;
    lsb_pkg::mem_op_t mem_op;
    lsb_pkg::addr_t   mem_addr;
    lsb_pkg::data_t   mem_wdata;
    lsb_pkg::tag_t    mem_tag;

    // memory to arbiter
    logic             rsp_en;
    lsb_pkg::tag_t    rsp_tag;
    lsb_pkg::data_t   rsp_data;

    ls_buffer #(.NUM_TAGS(NUM_TAGS)) u_ls_buffer (
        .clk         (clk),
        .rst         (rst),
        .dp_en       (dp_en),
        .dp_op       (dp_op),
        .dp_tag      (dp_tag),
        .dp_imm      (dp_imm),
        .dp_rs1_tag  (dp_rs1_tag),
        .dp_rs1_data (dp_rs1_data),
        .dp_rs2_tag  (dp_rs2_tag),
        .dp_rs2_data (dp_rs2_data),
        .commit_en   (commit_en),
        .commit_tag  (commit_tag),
        .cdb_en      (cdb_en),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_tag     (mem_tag),
        .full        (full)
    );

    data_mem #(.MEM_BYTES(MEM_BYTES)) u_data_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_tag   (mem_tag),
        .rsp_en    (rsp_en),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

    // CDB output also feeds back into the buffer
    cdb_arbiter u_cdb_arbiter (
        .clk      (clk),
        .rst      (rst),
        .rsp_en   (rsp_en),
        .rsp_tag  (rsp_tag),
        .rsp_data (rsp_data),
        .ex_en    (ex_en),
        .ex_tag   (ex_tag),
        .ex_data  (ex_data),
        .cdb_en   (cdb_en),
        .cdb_tag  (cdb_tag),
        .cdb_data (cdb_data),
        .ex_stall (ex_stall)
    );

endmodule

`default_nettype wire

//--- hw/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter (
    input  wire logic           clk,
    input  wire logic           rst,

    input  wire logic           rsp_en,
    input  wire lsb_pkg::tag_t  rsp_tag,
    input  wire lsb_pkg::data_t rsp_data,

    input  wire logic           ex_en,
    input  wire lsb_pkg::tag_t  ex_tag,
    input  wire lsb_pkg::data_t ex_data,

    output logic                cdb_en,
    output lsb_pkg::tag_t       cdb_tag,
    output lsb_pkg::data_t      cdb_data,
    output logic                ex_stall
);

    // execute unit holds its result while stalled
    assign ex_stall = rsp_en && ex_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_en <= 1'b0;
        end else begin
            cdb_en <= rsp_en || ex_en;
        end
    end

    // load response has priority
    always_ff @(posedge clk) begin
        if (rsp_en) begin
            cdb_tag  <= rsp_tag;
            cdb_data <= rsp_data;
        end else if (ex_en) begin
            cdb_tag  <= ex_tag;
            cdb_data <= ex_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`default_nettype none

module data_mem #(
    parameter int MEM_BYTES = 1024
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             mem_en,
    input  wire logic             mem_we,
    input  wire lsb_pkg::mem_op_t mem_op,
    input  wire lsb_pkg::addr_t   mem_addr,
    input  wire lsb_pkg::data_t   mem_wdata,
    input  wire lsb_pkg::tag_t    mem_tag,
    output logic                  rsp_en,
    output lsb_pkg::tag_t         rsp_tag,
    output lsb_pkg::data_t        rsp_data
);

    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];

    // stage 1 request
    logic             s1_en;
    logic             s1_we;
    lsb_pkg::mem_op_t s1_op;
    lsb_pkg::addr_t   s1_addr;
    lsb_pkg::data_t   s1_wdata;
    lsb_pkg::tag_t    s1_tag;

    logic [AW-1:0]  a0;
    logic [AW-1:0]  a1;
    logic [AW-1:0]  a2;
    logic [AW-1:0]  a3;
    logic [7:0]     b0;
    logic [7:0]     b1;
    logic [7:0]     b2;
    logic [7:0]     b3;
    lsb_pkg::len_t  s1_len;
    lsb_pkg::data_t ld_val;

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_en  <= 1'b0;
            s1_we  <= 1'b0;
            rsp_en <= 1'b0;
        end else begin
            s1_en  <= mem_en;
            s1_we  <= mem_we;
            rsp_en <= s1_en && !s1_we;
        end
    end

    always_ff @(posedge clk) begin
        s1_op    <= mem_op;
        s1_addr  <= mem_addr;
        s1_wdata <= mem_wdata;
        s1_tag   <= mem_tag;
        rsp_tag  <= s1_tag;
        rsp_data <= ld_val;
    end

    // little endian with addresses wrapping inside the array
    always_comb begin
        a0 = s1_addr[AW-1:0];
        a1 = a0 + 1'b1;
        a2 = a0 + 2'd2;
        a3 = a0 + 2'd3;
    end

    assign b0     = mem[a0];
    assign b1     = mem[a1];
    assign b2     = mem[a2];
    assign b3     = mem[a3];
    assign s1_len = lsb_pkg::op_len(s1_op);

    always_comb begin
        case (s1_op)
            lsb_pkg::LB:  ld_val = {{24{b0[7]}}, b0};
            lsb_pkg::LBU: ld_val = {24'h0, b0};
            lsb_pkg::LH:  ld_val = {{16{b1[7]}}, b1, b0};
            lsb_pkg::LHU: ld_val = {16'h0, b1, b0};
            default:      ld_val = {b3, b2, b1, b0};
        endcase
    end

    // write lands two edges after the request
    always_ff @(posedge clk) begin
        if (s1_en && s1_we) begin
            mem[a0] <= s1_wdata[7:0];
            if (s1_len != lsb_pkg::LEN_1) begin
                mem[a1] <= s1_wdata[15:8];
            end
            if (s1_len == lsb_pkg::LEN_4) begin
                mem[a2] <= s1_wdata[23:16];
                mem[a3] <= s1_wdata[31:24];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ls_buffer.sv
`default_nettype none

module ls_buffer #(
    parameter int NUM_TAGS = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             dp_en,
    input  wire lsb_pkg::mem_op_t dp_op,
    input  wire lsb_pkg::tag_t    dp_tag,
    input  wire lsb_pkg::imm_t    dp_imm,
    input  wire lsb_pkg::tag_t    dp_rs1_tag,
    input  wire lsb_pkg::data_t   dp_rs1_data,
    input  wire lsb_pkg::tag_t    dp_rs2_tag,
    input  wire lsb_pkg::data_t   dp_rs2_data,

    input  wire logic             commit_en,
    input  wire lsb_pkg::tag_t    commit_tag,

    input  wire logic             cdb_en,
    input  wire lsb_pkg::tag_t    cdb_tag,
    input  wire lsb_pkg::data_t   cdb_data,

    output logic                  mem_en,
    output logic                  mem_we,
    output lsb_pkg::mem_op_t      mem_op,
    output lsb_pkg::addr_t        mem_addr,
    output lsb_pkg::data_t        mem_wdata,
    output lsb_pkg::tag_t         mem_tag,
    output logic                  full
);

    // entry state indexed by reorder tag
    logic [NUM_TAGS-1:0] occupied;
    logic [NUM_TAGS-1:0] issued;
    lsb_pkg::mem_op_t    op       [NUM_TAGS];
    lsb_pkg::imm_t       imm      [NUM_TAGS];
    lsb_pkg::tag_t       rs1_tag  [NUM_TAGS];
    lsb_pkg::data_t      rs1_data [NUM_TAGS];
    logic [NUM_TAGS-1:0] rs1_rdy;
    lsb_pkg::tag_t       rs2_tag  [NUM_TAGS];
    lsb_pkg::data_t      rs2_data [NUM_TAGS];
    logic [NUM_TAGS-1:0] rs2_rdy;

    logic           st_go;
    logic           ld_hit;
    lsb_pkg::tag_t  ld_sel;
    lsb_pkg::tag_t  req_tag;
    lsb_pkg::addr_t req_addr;
    logic           dp_ok;
    logic           ld_done;

    // tag 0 never holds an entry
    assign full = &occupied[NUM_TAGS-1:1];

    assign dp_ok   = dp_en && (dp_op != lsb_pkg::NONE);
    assign ld_done = cdb_en && occupied[cdb_tag] && issued[cdb_tag];

    assign st_go = commit_en && occupied[commit_tag] && lsb_pkg::is_store(op[commit_tag]);

    // lowest ready load wins
    always_comb begin
        ld_hit = 1'b0;
        ld_sel = '0;
        for (int i = NUM_TAGS - 1; i >= 1; i--) begin
            if (occupied[i] && !issued[i] && rs1_rdy[i] && lsb_pkg::is_load(op[i])) begin
                ld_hit = 1'b1;
                ld_sel = lsb_pkg::tag_t'(i);
            end
        end
    end

    // commit beats load issue
    assign req_tag  = st_go ? commit_tag : ld_sel;
    assign req_addr = rs1_data[req_tag] + lsb_pkg::sext_imm(imm[req_tag]);

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
            issued   <= '0;
            mem_en   <= 1'b0;
            mem_we   <= 1'b0;
        end else begin
            mem_en <= 1'b0;
            mem_we <= 1'b0;
            if (st_go) begin
                mem_en               <= 1'b1;
                mem_we               <= 1'b1;
                occupied[commit_tag] <= 1'b0;
            end else if (ld_hit) begin
                mem_en         <= 1'b1;
                issued[ld_sel] <= 1'b1;
            end
            // load result seen on the bus
            if (ld_done) begin
                occupied[cdb_tag] <= 1'b0;
                issued[cdb_tag]   <= 1'b0;
            end
            if (dp_ok) begin
                occupied[dp_tag] <= 1'b1;
                issued[dp_tag]   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_op    <= op[req_tag];
        mem_addr  <= req_addr;
        mem_wdata <= rs2_data[req_tag];
        mem_tag   <= req_tag;

        // operand wakeup from the CDB
        if (cdb_en) begin
            for (int i = 1; i < NUM_TAGS; i++) begin
                if (occupied[i] && !rs1_rdy[i] && rs1_tag[i] == cdb_tag) begin
                    rs1_rdy[i]  <= 1'b1;
                    rs1_data[i] <= cdb_data;
                end
                if (occupied[i] && !rs2_rdy[i] && rs2_tag[i] == cdb_tag) begin
                    rs2_rdy[i]  <= 1'b1;
                    rs2_data[i] <= cdb_data;
                end
            end
        end

        if (dp_ok) begin
            op[dp_tag]      <= dp_op;
            imm[dp_tag]     <= dp_imm;
            rs1_tag[dp_tag] <= dp_rs1_tag;
            rs2_tag[dp_tag] <= dp_rs2_tag;
            // grab a same-cycle broadcast as well
            if (dp_rs1_tag == '0) begin
                rs1_rdy[dp_tag]  <= 1'b1;
                rs1_data[dp_tag] <= dp_rs1_data;
            end else if (cdb_en && cdb_tag == dp_rs1_tag) begin
                rs1_rdy[dp_tag]  <= 1'b1;
                rs1_data[dp_tag] <= cdb_data;
            end else begin
                rs1_rdy[dp_tag]  <= 1'b0;
                rs1_data[dp_tag] <= dp_rs1_data;
            end
            if (dp_rs2_tag == '0) begin
                rs2_rdy[dp_tag]  <= 1'b1;
                rs2_data[dp_tag] <= dp_rs2_data;
            end else if (cdb_en && cdb_tag == dp_rs2_tag) begin
                rs2_rdy[dp_tag]  <= 1'b1;
                rs2_data[dp_tag] <= cdb_data;
            end else begin
                rs2_rdy[dp_tag]  <= 1'b0;
                rs2_data[dp_tag] <= dp_rs2_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsb_pkg.sv
`default_nettype none

package lsb_pkg;

    typedef logic [3:0]         tag_t;
    typedef logic [31:0]        data_t;
    typedef logic [31:0]        addr_t;
    typedef logic signed [11:0] imm_t;
    typedef logic [1:0]         len_t;

    // access sizes
    localparam len_t LEN_1 = 2'd0;
    localparam len_t LEN_2 = 2'd1;
    localparam len_t LEN_4 = 2'd2;

    // NONE is skipped by dispatch
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_t;

    function automatic logic is_load(mem_op_t op);
        return (op == LB) || (op == LH) || (op == LW) || (op == LBU) || (op == LHU);
    endfunction

    function automatic logic is_store(mem_op_t op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    function automatic len_t op_len(mem_op_t op);
        case (op)
            LB, LBU, SB: return LEN_1;
            LH, LHU, SH: return LEN_2;
            default:     return LEN_4;
        endcase
    endfunction

    function automatic addr_t sext_imm(imm_t imm);
        return {{20{imm[11]}}, imm};
    endfunction

endpackage

`default_nettype wire
